/* verilog/dcache_cfg_pkg.sv */
// geometry of the write-through L1 data cache memory block
// read port count, ways, sets, banks and the derived field widths

`default_nettype none

package dcache_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // ports and associativity
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NumRdPorts = 3;
  localparam int unsigned RdSelBits  = $clog2(NumRdPorts);
  localparam int unsigned NumWays    = 4;

  ////////////////////////////////////////////////////////////////////////////
  // word and line layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned XlenBits      = 32;
  localparam int unsigned WordBytes     = XlenBits / 8;
  localparam int unsigned WordAlignBits = $clog2(WordBytes);
  localparam int unsigned LineBits      = 128;
  localparam int unsigned LineBytes     = LineBits / 8;

  // one bank per word offset of the line
  localparam int unsigned NumBanks    = LineBits / XlenBits;
  localparam int unsigned BankSelBits = $clog2(NumBanks);
  localparam int unsigned OffsetBits  = $clog2(LineBytes);

  ////////////////////////////////////////////////////////////////////////////
  // address split
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned IdxBits = 6;
  localparam int unsigned NumSets = 2 ** IdxBits;
  localparam int unsigned TagBits = 16;

endpackage

`default_nettype wire

/* verilog/dcache_types_pkg.sv */
// data types of the cache memory block
// address fields, words, byte enables and per-way vectors
// tag entry that the tag RAMs hold

`default_nettype none

package dcache_types_pkg;
  import dcache_cfg_pkg::*;

  // address fields
  typedef logic [TagBits-1:0]     tag_t;
  typedef logic [IdxBits-1:0]     idx_t;
  typedef logic [OffsetBits-1:0]  off_t;
  typedef logic [BankSelBits-1:0] bank_sel_t;

  // one word and its byte enables
  typedef logic [XlenBits-1:0]  word_t;
  typedef logic [WordBytes-1:0] word_be_t;

  // way vectors, a data bank row holds one word per way
  typedef logic [NumWays-1:0]         way_vec_t;
  typedef word_t [NumWays-1:0]        way_words_t;
  typedef word_be_t [NumWays-1:0]     way_be_t;

  // valid bit sits above the tag
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  typedef logic [RdSelBits-1:0] port_sel_t;

endpackage

`default_nettype wire

/* verilog/dcache_bank_if.sv */
// bundle of all data bank signals
// control side, RAM side and the read-only view of the bank outputs

`default_nettype none

interface dcache_bank_if;

  logic [dcache_cfg_pkg::NumBanks-1:0]                                req;
  logic [dcache_cfg_pkg::NumBanks-1:0]                                we;
  dcache_types_pkg::idx_t [dcache_cfg_pkg::NumBanks-1:0]              idx;
  dcache_types_pkg::way_be_t [dcache_cfg_pkg::NumBanks-1:0]           be;
  dcache_types_pkg::way_words_t [dcache_cfg_pkg::NumBanks-1:0]        wdata;
  dcache_types_pkg::way_words_t [dcache_cfg_pkg::NumBanks-1:0]        rdata;

  // request steering
  modport ctrl (
    output req, we, idx, be, wdata
  );

  // the bank RAMs
  modport ram (
    input  req, we, idx, be, wdata,
    output rdata
  );

  // readout mux only needs the bank outputs
  modport rd (
    input rdata
  );

endinterface

`default_nettype wire

/* verilog/dcache_sram.sv */
// single-port synchronous RAM with byte lanes
// payload given as a type, lanes split the payload evenly

`default_nettype none

module dcache_sram #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned NumWords  = dcache_cfg_pkg::NumSets,
  parameter int unsigned NumBytes  = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  dcache_types_pkg::idx_t addr_i,
  input  logic [NumBytes-1:0]    be_i,
  input  payload_t               wdata_i,
  output payload_t               rdata_o
);

  localparam int unsigned Bits     = $bits(payload_t);
  // last lane may be narrower when the payload is not a byte multiple
  localparam int unsigned LaneBits = (Bits + NumBytes - 1) / NumBytes;

  logic [Bits-1:0] mem_q [NumWords];
  logic [Bits-1:0] bit_mask;
  logic [Bits-1:0] wdata_bits;

  assign wdata_bits = wdata_i;

  always_comb begin
    for (int i = 0; i < Bits; i++) begin
      bit_mask[i] = be_i[i / LaneBits];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~bit_mask) | (wdata_bits & bit_mask);
    end
  end

  // read word is held until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= payload_t'(mem_q[addr_i]);
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_rd_arbiter.sv */
// read port arbiter
// high priority requests mask low priority ones, then round robin
// pointer moves past the granted port on every accepted grant

`default_nettype none

module dcache_rd_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [dcache_cfg_pkg::NumRdPorts-1:0] rd_req_i,
  input  logic [dcache_cfg_pkg::NumRdPorts-1:0] rd_prio_i,
  input  logic                                  hold_i,
  output logic [dcache_cfg_pkg::NumRdPorts-1:0] rd_ack_o,
  output logic                                  gnt_o,
  output dcache_types_pkg::port_sel_t           sel_o
);

  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;

  logic [NumRdPorts-1:0] req_prio;
  logic [NumRdPorts-1:0] req_masked;
  port_sel_t             ptr_d, ptr_q;

  ////////////////////////////////////////////////////////////////////////////
  // priority masking
  ////////////////////////////////////////////////////////////////////////////

  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  ////////////////////////////////////////////////////////////////////////////
  // round robin pick
  ////////////////////////////////////////////////////////////////////////////

  // first requester at or after the pointer, circular
  always_comb begin : p_pick
    int unsigned cand;
    logic        found;
    found = 1'b0;
    sel_o = ptr_q;
    for (int unsigned i = 0; i < NumRdPorts; i++) begin
      cand = (int'(ptr_q) + i) % NumRdPorts;
      if (!found && req_masked[cand]) begin
        found = 1'b1;
        sel_o = port_sel_t'(cand);
      end
    end
  end

  // a line write holds off every read
  assign gnt_o = (|req_masked) & ~hold_i;

  always_comb begin
    for (int unsigned i = 0; i < NumRdPorts; i++) begin
      rd_ack_o[i] = gnt_o && (sel_o == port_sel_t'(i));
    end
  end

  assign ptr_d = (sel_o == port_sel_t'(NumRdPorts - 1)) ? '0 : sel_o + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (gnt_o) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_bank_ctrl.sv */
// bank and tag RAM request steering
// line writes, word writes and read lookups, word write collision test

`default_nettype none

module dcache_bank_ctrl (
  input  logic                                                   gnt_i,
  input  dcache_types_pkg::port_sel_t                            sel_i,
  input  dcache_types_pkg::idx_t [dcache_cfg_pkg::NumRdPorts-1:0] rd_idx_i,
  input  dcache_types_pkg::off_t [dcache_cfg_pkg::NumRdPorts-1:0] rd_off_i,
  input  logic [dcache_cfg_pkg::NumRdPorts-1:0]                  rd_tag_only_i,
  input  logic                                                   wr_cl_vld_i,
  input  dcache_types_pkg::way_vec_t                             wr_cl_we_i,
  input  dcache_types_pkg::tag_t                                 wr_cl_tag_i,
  input  dcache_types_pkg::idx_t                                 wr_cl_idx_i,
  input  dcache_types_pkg::off_t                                 wr_cl_off_i,
  input  logic [dcache_cfg_pkg::LineBits-1:0]                    wr_cl_data_i,
  input  logic [dcache_cfg_pkg::LineBytes-1:0]                   wr_cl_be_i,
  input  dcache_types_pkg::way_vec_t                             wr_vld_bits_i,
  input  dcache_types_pkg::way_vec_t                             wr_req_i,
  input  dcache_types_pkg::idx_t                                 wr_idx_i,
  input  dcache_types_pkg::off_t                                 wr_off_i,
  input  dcache_types_pkg::word_t                                wr_data_i,
  input  dcache_types_pkg::word_be_t                             wr_be_i,
  output logic                                                   wr_ack_o,
  output dcache_types_pkg::way_vec_t                             tag_req_o,
  output dcache_types_pkg::idx_t                                 tag_idx_o,
  output dcache_types_pkg::tag_entry_t [dcache_cfg_pkg::NumWays-1:0] tag_wdata_o,
  output dcache_types_pkg::off_t                                 lookup_off_o,
  dcache_bank_if.ctrl                                            bank
);

  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;

  bank_sel_t rd_bank;
  bank_sel_t wr_bank;
  logic      rd_data;

  assign rd_bank = rd_off_i[sel_i][OffsetBits-1:WordAlignBits];
  assign wr_bank = wr_off_i[OffsetBits-1:WordAlignBits];
  assign rd_data = gnt_i & ~rd_tag_only_i[sel_i];

  // word write loses only to a data read of the same bank
  assign wr_ack_o = ~wr_cl_vld_i & (|wr_req_i) & ~(rd_data && (rd_bank == wr_bank));

  ////////////////////////////////////////////////////////////////////////////
  // tag RAMs
  ////////////////////////////////////////////////////////////////////////////

  assign tag_req_o    = wr_cl_vld_i ? wr_cl_we_i : {NumWays{gnt_i}};
  assign tag_idx_o    = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[sel_i];
  assign lookup_off_o = wr_cl_vld_i ? wr_cl_off_i : rd_off_i[sel_i];

  always_comb begin
    for (int j = 0; j < NumWays; j++) begin
      tag_wdata_o[j].valid = wr_vld_bits_i[j];
      tag_wdata_o[j].tag   = wr_cl_tag_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data banks
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bank.req   = '0;
    bank.we    = '0;
    bank.idx   = {NumBanks{wr_idx_i}};
    bank.be    = '0;
    bank.wdata = {(NumBanks * NumWays){wr_data_i}};
    if (wr_cl_vld_i) begin
      // full line, each bank takes its word slice
      bank.req = '1;
      bank.we  = '1;
      bank.idx = {NumBanks{wr_cl_idx_i}};
      for (int k = 0; k < NumBanks; k++) begin
        for (int j = 0; j < NumWays; j++) begin
          bank.wdata[k][j] = wr_cl_data_i[k*XlenBits +: XlenBits];
          bank.be[k][j]    = wr_cl_we_i[j] ? wr_cl_be_i[k*WordBytes +: WordBytes] : '0;
        end
      end
    end else begin
      if (rd_data) begin
        bank.req[rd_bank] = 1'b1;
        bank.idx[rd_bank] = rd_idx_i[sel_i];
      end
      if (wr_ack_o) begin
        bank.req[wr_bank] = 1'b1;
        bank.we[wr_bank]  = 1'b1;
        for (int j = 0; j < NumWays; j++) begin
          bank.be[wr_bank][j] = wr_req_i[j] ? wr_be_i : '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_hit_select.sv */
// lookup state of the read in flight
// tag compare per way, one-hot hit and word readout mux

`default_nettype none

module dcache_hit_select (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  logic                                                       gnt_i,
  input  logic                                                       cl_write_i,
  input  dcache_types_pkg::off_t                                     lookup_off_i,
  input  dcache_types_pkg::port_sel_t                                sel_i,
  input  dcache_types_pkg::tag_t [dcache_cfg_pkg::NumRdPorts-1:0]    rd_tag_i,
  input  dcache_types_pkg::tag_entry_t [dcache_cfg_pkg::NumWays-1:0] tag_rdata_i,
  dcache_bank_if.rd                                                  bank,
  output dcache_types_pkg::way_vec_t                                 rd_vld_bits_o,
  output dcache_types_pkg::way_vec_t                                 rd_hit_oh_o,
  output dcache_types_pkg::word_t                                    rd_data_o
);

  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;

  port_sel_t sel_q;
  bank_sel_t bank_q;
  logic      cmp_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q    <= '0;
      bank_q   <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      sel_q    <= sel_i;
      bank_q   <= lookup_off_i[OffsetBits-1:WordAlignBits];
      // no compare in the cycle after a line write
      cmp_en_q <= gnt_i & ~cl_write_i;
    end
  end

  // tag of the granted port arrives in this cycle
  always_comb begin
    for (int j = 0; j < NumWays; j++) begin
      rd_vld_bits_o[j] = tag_rdata_i[j].valid;
      rd_hit_oh_o[j]   = cmp_en_q & tag_rdata_i[j].valid
                         & (tag_rdata_i[j].tag == rd_tag_i[sel_q]);
    end
  end

  always_comb begin
    rd_data_o = '0;
    for (int j = 0; j < NumWays; j++) begin
      if (rd_hit_oh_o[j]) begin
        rd_data_o = bank.rdata[bank_q][j];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_mem.sv */
// memory block of the write-through L1 data cache
// read arbiter, bank steering, tag and data RAMs, hit logic

`default_nettype none

module dcache_mem (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // read ports
  input  logic [dcache_cfg_pkg::NumRdPorts-1:0]                   rd_req_i,
  input  logic [dcache_cfg_pkg::NumRdPorts-1:0]                   rd_prio_i,
  input  logic [dcache_cfg_pkg::NumRdPorts-1:0]                   rd_tag_only_i,
  input  dcache_types_pkg::idx_t [dcache_cfg_pkg::NumRdPorts-1:0] rd_idx_i,
  input  dcache_types_pkg::off_t [dcache_cfg_pkg::NumRdPorts-1:0] rd_off_i,
  input  dcache_types_pkg::tag_t [dcache_cfg_pkg::NumRdPorts-1:0] rd_tag_i,
  output logic [dcache_cfg_pkg::NumRdPorts-1:0]                   rd_ack_o,
  output dcache_types_pkg::way_vec_t                              rd_vld_bits_o,
  output dcache_types_pkg::way_vec_t                              rd_hit_oh_o,
  output dcache_types_pkg::word_t                                 rd_data_o,
  // line write
  input  logic                                                    wr_cl_vld_i,
  input  dcache_types_pkg::way_vec_t                              wr_cl_we_i,
  input  dcache_types_pkg::tag_t                                  wr_cl_tag_i,
  input  dcache_types_pkg::idx_t                                  wr_cl_idx_i,
  input  dcache_types_pkg::off_t                                  wr_cl_off_i,
  input  logic [dcache_cfg_pkg::LineBits-1:0]                     wr_cl_data_i,
  input  logic [dcache_cfg_pkg::LineBytes-1:0]                    wr_cl_be_i,
  input  dcache_types_pkg::way_vec_t                              wr_vld_bits_i,
  // single word write
  input  dcache_types_pkg::way_vec_t                              wr_req_i,
  input  dcache_types_pkg::idx_t                                  wr_idx_i,
  input  dcache_types_pkg::off_t                                  wr_off_i,
  input  dcache_types_pkg::word_t                                 wr_data_i,
  input  dcache_types_pkg::word_be_t                              wr_be_i,
  output logic                                                    wr_ack_o
);

  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;

  logic       gnt;
  port_sel_t  sel;
  way_vec_t   tag_req;
  idx_t       tag_idx;
  off_t       lookup_off;
  tag_entry_t [NumWays-1:0] tag_wdata;
  tag_entry_t [NumWays-1:0] tag_rdata;

  dcache_bank_if u_bank_if ();

  dcache_rd_arbiter u_rd_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_req_i  (rd_req_i),
    .rd_prio_i (rd_prio_i),
    .hold_i    (wr_cl_vld_i),
    .rd_ack_o  (rd_ack_o),
    .gnt_o     (gnt),
    .sel_o     (sel)
  );

  dcache_bank_ctrl u_bank_ctrl (
    .gnt_i         (gnt),
    .sel_i         (sel),
    .rd_idx_i      (rd_idx_i),
    .rd_off_i      (rd_off_i),
    .rd_tag_only_i (rd_tag_only_i),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_tag_i   (wr_cl_tag_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_off_i   (wr_cl_off_i),
    .wr_cl_data_i  (wr_cl_data_i),
    .wr_cl_be_i    (wr_cl_be_i),
    .wr_vld_bits_i (wr_vld_bits_i),
    .wr_req_i      (wr_req_i),
    .wr_idx_i      (wr_idx_i),
    .wr_off_i      (wr_off_i),
    .wr_data_i     (wr_data_i),
    .wr_be_i       (wr_be_i),
    .wr_ack_o      (wr_ack_o),
    .tag_req_o     (tag_req),
    .tag_idx_o     (tag_idx),
    .tag_wdata_o   (tag_wdata),
    .lookup_off_o  (lookup_off),
    .bank          (u_bank_if)
  );

  ////////////////////////////////////////////////////////////////////////////
  // arrays
  ////////////////////////////////////////////////////////////////////////////

  // bank k holds word k of every way
  for (genvar k = 0; k < NumBanks; k++) begin : gen_data_bank
    dcache_sram #(
      .payload_t (way_words_t),
      .NumWords  (NumSets),
      .NumBytes  (NumWays * WordBytes)
    ) u_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (u_bank_if.req[k]),
      .we_i    (u_bank_if.we[k]),
      .addr_i  (u_bank_if.idx[k]),
      .be_i    (u_bank_if.be[k]),
      .wdata_i (u_bank_if.wdata[k]),
      .rdata_o (u_bank_if.rdata[k])
    );
  end

  for (genvar j = 0; j < NumWays; j++) begin : gen_tag_way
    dcache_sram #(
      .payload_t (tag_entry_t),
      .NumWords  (NumSets),
      .NumBytes  (1)
    ) u_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req[j]),
      .we_i    (wr_cl_vld_i),
      .addr_i  (tag_idx),
      .be_i    (1'b1),
      .wdata_i (tag_wdata[j]),
      .rdata_o (tag_rdata[j])
    );
  end

  dcache_hit_select u_hit_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .gnt_i         (gnt),
    .cl_write_i    (wr_cl_vld_i),
    .lookup_off_i  (lookup_off),
    .sel_i         (sel),
    .rd_tag_i      (rd_tag_i),
    .tag_rdata_i   (tag_rdata),
    .bank          (u_bank_if),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

`default_nettype wire

/* verif/dcache_checker.sv */
// checker for the cache memory block
// model of tag, valid and data arrays and of the read arbiter
// compares acknowledges every cycle and results after each grant

`default_nettype none

module dcache_checker (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic [2:0]                                              rd_req_i,
  input  logic [2:0]                                              rd_prio_i,
  input  logic [2:0]                                              rd_tag_only_i,
  input  dcache_types_pkg::idx_t [2:0]                            rd_idx_i,
  input  dcache_types_pkg::off_t [2:0]                            rd_off_i,
  input  dcache_types_pkg::tag_t [2:0]                            rd_tag_i,
  input  logic [2:0]                                              rd_ack_o,
  input  logic [3:0]                                              rd_vld_bits_o,
  input  logic [3:0]                                              rd_hit_oh_o,
  input  logic [31:0]                                             rd_data_o,
  input  logic                                                    wr_cl_vld_i,
  input  logic [3:0]                                              wr_cl_we_i,
  input  logic [15:0]                                             wr_cl_tag_i,
  input  logic [5:0]                                              wr_cl_idx_i,
  input  logic [127:0]                                            wr_cl_data_i,
  input  logic [15:0]                                             wr_cl_be_i,
  input  logic [3:0]                                              wr_vld_bits_i,
  input  logic [3:0]                                              wr_req_i,
  input  logic [5:0]                                              wr_idx_i,
  input  logic [3:0]                                              wr_off_i,
  input  logic [31:0]                                             wr_data_i,
  input  logic [3:0]                                              wr_be_i,
  input  logic                                                    wr_ack_o,
  input  logic [2:0]                                              exp_rd_ack,
  input  logic                                                    exp_wr_ack,
  input  logic [3:0]                                              exp_hit,
  input  logic                                                    chk_hit,
  output int unsigned                                             ack_errs,
  output int unsigned                                             res_errs
);
  timeunit 1ns;
  timeprecision 100ps;

  logic        mv [64][4];
  logic [15:0] mt [64][4];
  logic [31:0] md [64][4][4];
  int unsigned ptr;
  // lookup captured in the grant cycle
  logic        p_gnt, p_tonly;
  int unsigned p_port;
  logic [3:0]  p_valid;
  logic [15:0] p_tag [4];
  logic [31:0] p_word [4];

  initial begin
    ack_errs = 0;
    res_errs = 0;
  end

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] got, input bit is_ack);
    if (got !== exp) begin
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t", name, exp, got, $time);
      if (is_ack) ack_errs++;
      else res_errs++;
    end
  endtask

  always @(negedge clk_i) begin : p_check
    logic [2:0]  req_m, e_ack;
    logic [3:0]  e_hit;
    logic [31:0] e_data;
    logic        e_wack;
    int unsigned cand, gp, rb, wb;
    if (!rst_ni) begin
      p_gnt = 1'b0;
      ptr   = 0;
    end else begin
      // result of the read granted one cycle ago
      e_hit  = '0;
      e_data = '0;
      for (int j = 0; j < 4; j++) begin
        if (p_gnt && p_valid[j] && p_tag[j] == rd_tag_i[p_port]) begin
          e_hit[j] = 1'b1;
          e_data   = p_word[j];
        end
      end
      check_field("rd_hit_oh_o", e_hit, rd_hit_oh_o, 0);
      if (chk_hit) check_field("rd_hit_oh_o (table)", exp_hit, rd_hit_oh_o, 0);
      if (p_gnt) check_field("rd_vld_bits_o", p_valid, rd_vld_bits_o, 0);
      if (p_gnt && !p_tonly) check_field("rd_data_o", e_data, rd_data_o, 0);

      // high priority masks low, then first requester from the pointer
      req_m = (|(rd_req_i & rd_prio_i)) ? (rd_req_i & rd_prio_i) : rd_req_i;
      e_ack = '0;
      gp    = 0;
      for (int i = 0; i < 3; i++) begin
        cand = (ptr + i) % 3;
        if (!wr_cl_vld_i && e_ack == 0 && req_m[cand]) begin
          e_ack[cand] = 1'b1;
          gp          = cand;
        end
      end
      check_field("rd_ack_o", e_ack, rd_ack_o, 1);
      check_field("rd_ack_o (table)", exp_rd_ack, rd_ack_o, 1);

      rb     = rd_off_i[gp][3:2];
      wb     = wr_off_i[3:2];
      e_wack = !wr_cl_vld_i && (|wr_req_i)
               && !((|e_ack) && !rd_tag_only_i[gp] && rb == wb);
      check_field("wr_ack_o", e_wack, wr_ack_o, 1);
      check_field("wr_ack_o (table)", exp_wr_ack, wr_ack_o, 1);

      p_gnt   = |e_ack;
      p_port  = gp;
      p_tonly = rd_tag_only_i[gp];
      for (int j = 0; j < 4; j++) begin
        p_valid[j] = mv[rd_idx_i[gp]][j];
        p_tag[j]   = mt[rd_idx_i[gp]][j];
        p_word[j]  = md[rd_idx_i[gp]][j][rb];
      end

      // array updates land at the next rising edge
      if (wr_cl_vld_i) begin
        for (int j = 0; j < 4; j++) begin
          if (wr_cl_we_i[j]) begin
            mv[wr_cl_idx_i][j] = wr_vld_bits_i[j];
            mt[wr_cl_idx_i][j] = wr_cl_tag_i;
            for (int k = 0; k < 4; k++) begin
              for (int b = 0; b < 4; b++) begin
                if (wr_cl_be_i[k*4+b]) begin
                  md[wr_cl_idx_i][j][k][b*8 +: 8] = wr_cl_data_i[k*32+b*8 +: 8];
                end
              end
            end
          end
        end
      end
      if (e_wack) begin
        for (int j = 0; j < 4; j++) begin
          for (int b = 0; b < 4; b++) begin
            if (wr_req_i[j] && wr_be_i[b]) md[wr_idx_i][j][wb][b*8 +: 8] = wr_data_i[b*8 +: 8];
          end
        end
      end
      if (p_gnt) ptr = (gp + 1) % 3;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_dcache_mem.sv */
// testbench top for the cache memory block
// clock, reset, stimulus table, drive loop, watchdog and DUT instance

`default_nettype none

module tb_dcache_mem;
  timeunit 1ns;
  timeprecision 100ps;

  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;

  localparam int unsigned NumEntries = 20;
  localparam tag_t TagA = 16'h1a2b;
  localparam tag_t TagB = 16'h3c4d;
  localparam tag_t TagX = 16'h7777;

  typedef struct packed {
    logic [2:0]    req;
    logic [2:0]    prio;
    logic [2:0]    tonly;
    idx_t          idx;
    off_t          off;
    tag_t          tag_nxt;
    logic          cl;
    way_vec_t      cl_we;
    way_vec_t      cl_vbits;
    tag_t          cl_tag;
    idx_t          cl_idx;
    logic [127:0]  cl_data;
    way_vec_t      wr_req;
    idx_t          wr_idx;
    off_t          wr_off;
    word_be_t      wr_be;
    word_t         wr_data;
    logic [2:0]    exp_rack;
    logic          exp_wack;
    way_vec_t      exp_hit;
    logic          chk_hit;
  } entry_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic [NumRdPorts-1:0] rd_req_i, rd_prio_i, rd_tag_only_i, rd_ack_o;
  idx_t [NumRdPorts-1:0] rd_idx_i;
  off_t [NumRdPorts-1:0] rd_off_i;
  tag_t [NumRdPorts-1:0] rd_tag_i;
  way_vec_t rd_vld_bits_o, rd_hit_oh_o, wr_cl_we_i, wr_vld_bits_i, wr_req_i, exp_hit;
  word_t rd_data_o, wr_data_i;
  logic wr_cl_vld_i, wr_ack_o, exp_wr_ack, chk_hit;
  tag_t wr_cl_tag_i;
  idx_t wr_cl_idx_i, wr_idx_i;
  off_t wr_cl_off_i, wr_off_i;
  logic [LineBits-1:0] wr_cl_data_i;
  logic [LineBytes-1:0] wr_cl_be_i;
  word_be_t wr_be_i;
  logic [2:0] exp_rd_ack;
  int unsigned ack_errs, res_errs;
  entry_t tbl [NumEntries];

  always #2 clk_i = ~clk_i;

  task automatic read_req(input int n, input logic [2:0] req, input logic [2:0] prio,
                          input logic [2:0] tonly, input idx_t idx, input off_t off,
                          input tag_t tag);
    tbl[n].req     = req;
    tbl[n].prio    = prio;
    tbl[n].tonly   = tonly;
    tbl[n].idx     = idx;
    tbl[n].off     = off;
    tbl[n].tag_nxt = tag;
  endtask

  // refill data is random, every way in the vector gets the same line
  task automatic refill_line(input int n, input way_vec_t we, input way_vec_t vbits,
                             input tag_t tag, input idx_t idx);
    tbl[n].cl       = 1'b1;
    tbl[n].cl_we    = we;
    tbl[n].cl_vbits = vbits;
    tbl[n].cl_tag   = tag;
    tbl[n].cl_idx   = idx;
    tbl[n].cl_data  = {$urandom(), $urandom(), $urandom(), $urandom()};
  endtask

  task automatic write_word(input int n, input way_vec_t req, input idx_t idx, input off_t off,
                            input word_be_t be, input word_t data);
    tbl[n].wr_req  = req;
    tbl[n].wr_idx  = idx;
    tbl[n].wr_off  = off;
    tbl[n].wr_be   = be;
    tbl[n].wr_data = data;
  endtask

  task automatic expect_resp(input int n, input logic [2:0] rack, input logic wack,
                             input way_vec_t hit, input logic chk);
    tbl[n].exp_rack = rack;
    tbl[n].exp_wack = wack;
    tbl[n].exp_hit  = hit;
    tbl[n].chk_hit  = chk;
  endtask

  task automatic drive_entry(input entry_t e);
    idx_t [NumRdPorts-1:0] idx_v;
    off_t [NumRdPorts-1:0] off_v;
    // only the port expected to win carries the entry's address
    for (int p = 0; p < NumRdPorts; p++) begin
      idx_v[p] = e.exp_rack[p] ? e.idx : e.idx ^ 6'h01;
      off_v[p] = e.exp_rack[p] ? e.off : e.off ^ 4'h4;
    end
    rd_req_i      <= e.req;
    rd_prio_i     <= e.prio;
    rd_tag_only_i <= e.tonly;
    rd_idx_i      <= idx_v;
    rd_off_i      <= off_v;
    wr_cl_vld_i   <= e.cl;
    wr_cl_we_i    <= e.cl_we;
    wr_vld_bits_i <= e.cl_vbits;
    wr_cl_tag_i   <= e.cl_tag;
    wr_cl_idx_i   <= e.cl_idx;
    wr_cl_off_i   <= '0;
    wr_cl_data_i  <= e.cl_data;
    wr_cl_be_i    <= '1;
    wr_req_i      <= e.wr_req;
    wr_idx_i      <= e.wr_idx;
    wr_off_i      <= e.wr_off;
    wr_be_i       <= e.wr_be;
    wr_data_i     <= e.wr_data;
    exp_rd_ack    <= e.exp_rack;
    exp_wr_ack    <= e.exp_wack;
  endtask

  // only the port granted one cycle earlier gets the entry's tag
  task automatic present_result(input entry_t e);
    tag_t [NumRdPorts-1:0] tag_v;
    for (int p = 0; p < NumRdPorts; p++) begin
      tag_v[p] = e.exp_rack[p] ? e.tag_nxt : ~e.tag_nxt;
    end
    rd_tag_i <= tag_v;
    exp_hit  <= e.exp_hit;
    chk_hit  <= e.chk_hit;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    entry_t idle;
    idle = '0;
    void'($urandom(32'hc997_2616));
    for (int n = 0; n < NumEntries; n++) begin
      tbl[n] = '0;
    end
    // refills, reads and a word write are all held off by the line write
    refill_line(0, 4'hf, 4'b0001, TagA, 6'd5);
    read_req(0, 3'b001, 3'b000, 3'b000, 6'd5, 4'd0, TagA);
    write_word(0, 4'b0001, 6'd5, 4'd0, 4'hf, 32'h0bad_0bad);
    expect_resp(0, 3'b000, 1'b0, 4'b0000, 1'b1);
    refill_line(1, 4'b0100, 4'b0101, TagB, 6'd5);
    expect_resp(1, 3'b000, 1'b0, 4'b0000, 1'b1);
    refill_line(2, 4'hf, 4'b0010, TagA, 6'd9);
    expect_resp(2, 3'b000, 1'b0, 4'b0000, 1'b1);
    // every word of the refilled line
    for (int n = 3; n < 7; n++) begin
      read_req(n, 3'b001, 3'b000, 3'b000, 6'd5, off_t'((n - 3) * 4), TagA);
      expect_resp(n, 3'b001, 1'b0, 4'b0001, 1'b1);
    end
    read_req(7, 3'b010, 3'b000, 3'b000, 6'd5, 4'd4, TagB);
    expect_resp(7, 3'b010, 1'b0, 4'b0100, 1'b1);
    read_req(8, 3'b001, 3'b000, 3'b000, 6'd5, 4'd0, TagX);
    expect_resp(8, 3'b001, 1'b0, 4'b0000, 1'b1);
    read_req(9, 3'b100, 3'b000, 3'b100, 6'd9, 4'd0, TagA);
    expect_resp(9, 3'b100, 1'b0, 4'b0010, 1'b1);
    // partial word write, then read back
    write_word(10, 4'b0001, 6'd5, 4'd4, 4'b0011, 32'hdead_beef);
    expect_resp(10, 3'b000, 1'b1, 4'b0000, 1'b1);
    read_req(11, 3'b001, 3'b000, 3'b000, 6'd5, 4'd4, TagA);
    expect_resp(11, 3'b001, 1'b0, 4'b0001, 1'b1);
    // bank collisions
    read_req(12, 3'b001, 3'b000, 3'b000, 6'd5, 4'd8, TagA);
    write_word(12, 4'b0001, 6'd5, 4'd8, 4'hf, 32'h1234_5678);
    expect_resp(12, 3'b001, 1'b0, 4'b0001, 1'b1);
    read_req(13, 3'b010, 3'b000, 3'b000, 6'd5, 4'd0, TagA);
    write_word(13, 4'b0001, 6'd5, 4'd12, 4'b1100, 32'hcafe_f00d);
    expect_resp(13, 3'b010, 1'b1, 4'b0001, 1'b1);
    read_req(14, 3'b100, 3'b000, 3'b100, 6'd5, 4'd8, TagA);
    write_word(14, 4'b0001, 6'd5, 4'd8, 4'b0001, 32'h0000_00a5);
    expect_resp(14, 3'b100, 1'b1, 4'b0001, 1'b1);
    // priority, then the pointer rotates through all three ports
    read_req(15, 3'b101, 3'b100, 3'b000, 6'd5, 4'd0, TagA);
    expect_resp(15, 3'b100, 1'b0, 4'b0001, 1'b1);
    for (int n = 16; n < 19; n++) begin
      read_req(n, 3'b111, 3'b000, 3'b000, 6'd5, 4'd12, TagA);
      expect_resp(n, 3'b001 << (n - 16), 1'b0, 4'b0001, 1'b1);
    end
    expect_resp(19, 3'b000, 1'b0, 4'b0000, 1'b1);

    rst_ni   <= 1'b0;
    rd_tag_i <= '0;
    exp_hit  <= '0;
    chk_hit  <= 1'b0;
    drive_entry(idle);
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    for (int n = 0; n < NumEntries; n++) begin
      @(posedge clk_i);
      drive_entry(tbl[n]);
      if (n > 0) begin
        present_result(tbl[n-1]);
      end
    end
    @(posedge clk_i);
    drive_entry(idle);
    present_result(tbl[NumEntries-1]);
    @(posedge clk_i);
    chk_hit <= 1'b0;
    // the checker has sampled the last cycle by the next rising edge
    @(posedge clk_i);

    $display("errors: ack %0d, result %0d", ack_errs, res_errs);
    if (ack_errs + res_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((NumEntries + 40) * 4);
    $display("timeout: the stimulus loop did not finish in time");
    $display("Test failed");
    $finish;
  end

  dcache_mem u_dcache_mem (.*);

  dcache_checker u_checker (.*);

endmodule

`default_nettype wire

/* vlog.f */
verilog/dcache_cfg_pkg.sv
verilog/dcache_types_pkg.sv
verilog/dcache_bank_if.sv
verilog/dcache_sram.sv
verilog/dcache_rd_arbiter.sv
verilog/dcache_bank_ctrl.sv
verilog/dcache_hit_select.sv
verilog/dcache_mem.sv
verif/dcache_checker.sv
verif/tb_dcache_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cache memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dcache_mem \
  -f vlog.f -o Vtb_dcache_mem \
  && ./obj_dir/Vtb_dcache_mem | tee sim.log \
  || { echo "build or simulation error"; exit 1; }

[ -s sim.log ] || { echo "no simulation log"; exit 1; }

grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
